/* vlog.f */
logic/asa_pkg.sv
logic/asa_ras_if.sv
logic/ram_1r1w.sv
logic/ras_decode.sv
logic/asa_process.sv
logic/asa_top.sv
tb/asa_tb.sv

/* Bender.yml */
package:
  name: asa_stage

sources:
  - logic/asa_pkg.sv
  - logic/asa_ras_if.sv
  - logic/ram_1r1w.sv
  - logic/ras_decode.sv
  - logic/asa_process.sv
  - logic/asa_top.sv
  - target: test
    files:
      - tb/asa_tb.sv

/* tb/asa_testdata.txt */
# P fid domain tclass mask | C time sub_exp sup_sci class2pri (all hex)
# K name type3 fid tid rci type1 discard domain src buf topic flows flags
#   then expected: vec discard pri mcast classifier tset taddr tdata
C 12a0 05 7 8d1b
P 01 3 0 7e
P 02 5 1 7f
P 03 2 2 6c
P 04 1 3 7e
P 05 0 5 1e
P 06 0 7 08
# Execute forwarding, input port and supervisor port removed.
K exec_fwd         0 01 04 2 1 0 3 5 123 5 88888721 f8  22 0 3 1 0 1 25 17
K sup_allowed      0 02 06 0 0 0 9 1 045 8 88880887 d0  80 0 2 1 0 0 00 00
# Table learning, then type3 packets read the stored sets.
K learn_flow       0 03 09 6 1 0 2 2 200 1 88888843 ff  00 0 1 0 0 1 49 17
K learn_topic      0 03 09 6 1 0 2 3 201 4 88888888 a0  1a 0 1 0 0 1 4c 17
K type3_both       1 03 09 1 0 0 0 4 202 8 88888888 80  18 0 1 0 0 0 00 00
K type3_default0   1 01 04 1 0 0 0 6 300 8 88888888 80  00 1 3 1 0 0 00 00
K set_default_flow 0 01 04 2 1 0 3 7 301 8 88888888 86  00 1 3 1 0 0 00 00
K type3_flow       1 01 04 1 0 0 0 8 302 8 88888888 80  04 0 3 1 0 0 00 00
# Drops and the classifier terminate notice.
K in_discard       0 02 06 0 0 1 9 9 3ff 8 88880887 d0  00 1 2 1 0 0 00 00
K domain_miss      0 01 04 2 1 0 4 a 010 5 88888721 f8  00 1 3 1 0 0 00 00
K terminate        0 02 06 3 0 0 0 b 011 3 88888887 78  80 0 2 1 1 0 00 00
# Priority per traffic class.
K pri_class5       0 05 00 0 0 0 0 c 012 8 88888884 d0  10 0 3 1 0 0 00 00
K pri_class7       0 06 00 0 0 0 0 d 013 8 88888884 d0  00 0 2 0 0 0 00 00
# Topic timer with a wrapping expiry time.
C ff10 20 7 8d1b
K timer_wrap       0 04 1f 0 1 0 1 e 014 6 88888888 a0  40 0 0 1 0 1 fe 1f

/* tb/asa_tb.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Action-set stage testbench. Replays policy writes, stage settings and
// packets from a data file and checks every enqueue request.
////////////////////////////////////////////////////////////////////////////

module asa_tb import asa_pkg::*; ();

	localparam int FID_NBITS      = 6;
	localparam int TID_NBITS      = 5;
	localparam int TIMEOUT_CYCLES = 20;

	logic                           clk;
	logic                           arst_n;
	logic                           in_valid;
	logic                           in_type3;
	logic [FID_NBITS-1:0]           in_fid;
	logic [TID_NBITS-1:0]           in_tid;
	logic [SCI_NBITS-1:0]           in_rci;
	logic                           in_type1;
	logic                           in_discard;
	logic [DOMAIN_NBITS-1:0]        in_domain_id;
	logic [SRC_PORT_NBITS-1:0]      in_src_port;
	logic [BUF_PTR_NBITS-1:0]       in_buf_ptr;
	ras_t                           in_ras;
	logic [REAL_TIME_NBITS-1:0]     current_time;
	logic [SUB_EXP_TIME_NBITS-1:0]  default_sub_exp_time;
	logic [SCI_NBITS-1:0]           supervisor_sci;
	logic [CLASS2PRI_NBITS-1:0]     class2pri;
	logic                           fp_wr;
	logic [FID_NBITS-1:0]           fp_waddr;
	flow_policy_t                   fp_wdata;
	logic                           classifier_valid;
	logic [FID_NBITS-1:0]           classifier_fid;
	logic                           tset_wr;
	logic [TID_NBITS+SCI_NBITS-1:0] tset_waddr;
	logic [SUB_EXP_TIME_NBITS-1:0]  tset_wdata;
	logic                           enq_req;
	logic                           enq_discard;
	logic                           enq_allow_mcast;
	logic [SCI_VEC_NBITS-1:0]       enq_vec;
	logic [PRI_NBITS-1:0]           enq_pri;
	logic [SRC_PORT_NBITS-1:0]      enq_src_port;
	logic [BUF_PTR_NBITS-1:0]       enq_buf_ptr;
	logic [TID_NBITS-1:0]           enq_tid;

	int               errors;
	int               tests;
	int               failed_tests;
	int               fd;
	int               rc;
	bit               timed_out;
	logic [8*8-1:0]   tag;
	logic [8*24-1:0]  test_name;
	logic [8*256-1:0] line;
	logic [31:0]      f_type3, f_fid, f_tid, f_rci, f_type1, f_disc, f_dom, f_src, f_buf;
	logic [31:0]      f_topic, f_flows, f_flags, f_tclass, f_mask;
	logic [31:0]      f_time, f_sub, f_sup, f_c2p;
	logic [31:0]      e_vec, e_disc, e_pri, e_mcast, e_cls, e_tset, e_taddr, e_tdata;

	asa_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %0s got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_idle();
		check_value("enq_req", enq_req, 0);
		check_value("classifier_valid", classifier_valid, 0);
		check_value("tset_wr", tset_wr, 0);
	endtask

	task automatic write_policy();
		@(posedge clk);
		#1;
		fp_wr    = 1'b1;
		fp_waddr = f_fid[FID_NBITS-1:0];
		fp_wdata = {f_dom[3:0], f_tclass[2:0], f_mask[6:0]};
		@(posedge clk);
		#1;
		fp_wr = 1'b0;
		check_idle();
	endtask

	task automatic set_config();
		@(posedge clk);
		#1;
		current_time         = f_time[15:0];
		default_sub_exp_time = f_sub[7:0];
		supervisor_sci       = f_sup[2:0];
		class2pri            = f_c2p[15:0];
	endtask

	task automatic run_packet();
		int          cycles;
		int          cls_cycle;
		int          errors_at_start;
		logic [31:0] cls_fid;
		errors_at_start = errors;
		@(posedge clk);
		#1;
		in_valid     = 1'b1;
		in_type3     = f_type3[0];
		in_fid       = f_fid[FID_NBITS-1:0];
		in_tid       = f_tid[TID_NBITS-1:0];
		in_rci       = f_rci[2:0];
		in_type1     = f_type1[0];
		in_discard   = f_disc[0];
		in_domain_id = f_dom[3:0];
		in_src_port  = f_src[3:0];
		in_buf_ptr   = f_buf[9:0];
		in_ras       = {f_topic[3:0], f_flows, f_flags[7:0]};
		cycles       = 0;
		cls_cycle    = 0;
		cls_fid      = '0;
		while (!enq_req && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0; // Single-cycle packet.
			cycles++;
			#1;
			if (classifier_valid && cls_cycle == 0) begin
				cls_cycle = cycles;
				cls_fid   = classifier_fid;
			end
		end
		if (!enq_req) begin
			$display("Timeout: %0s got no enqueue request within %0d cycles", test_name,
				TIMEOUT_CYCLES);
			errors++;
			timed_out = 1'b1;
		end else begin
			check_value("enq_req latency", cycles, 3);
			check_value("enq_vec", enq_vec, e_vec);
			check_value("enq_discard", enq_discard, e_disc);
			check_value("enq_pri", enq_pri, e_pri);
			check_value("enq_allow_mcast", enq_allow_mcast, e_mcast);
			check_value("enq_src_port", enq_src_port, f_src);
			check_value("enq_buf_ptr", enq_buf_ptr, f_buf);
			check_value("enq_tid", enq_tid, f_tid);
			check_value("classifier_valid cycle", cls_cycle, e_cls ? 2 : 0);
			if (e_cls)
				check_value("classifier_fid", cls_fid, f_tid);
			check_value("tset_wr", tset_wr, e_tset);
			if (e_tset) begin
				check_value("tset_waddr", tset_waddr, e_taddr);
				check_value("tset_wdata", tset_wdata, e_tdata);
			end
		end
		tests++;
		if (errors == errors_at_start) begin
			$display("%0s: ok", test_name);
		end else begin
			failed_tests++;
			$display("%0s: mismatch", test_name);
		end
	endtask

	initial begin
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		timed_out    = 1'b0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_type3     = 1'b0;
		in_fid       = '0;
		in_tid       = '0;
		in_rci       = '0;
		in_type1     = 1'b0;
		in_discard   = 1'b0;
		in_domain_id = '0;
		in_src_port  = '0;
		in_buf_ptr   = '0;
		in_ras       = '0;
		current_time         = '0;
		default_sub_exp_time = '0;
		supervisor_sci       = '0;
		class2pri            = '0;
		fp_wr                = 1'b0;
		fp_waddr             = '0;
		fp_wdata             = '0;

		repeat (4) begin
			@(posedge clk);
			#1;
			check_idle();
		end
		arst_n = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_idle();
		end
		tests++;
		if (errors == 0) begin
			$display("reset_idle: ok");
		end else begin
			failed_tests++;
			$display("reset_idle: mismatch");
		end

		fd = $fopen("tb/asa_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file tb/asa_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = '0;
				tag  = '0;
				rc   = $fgets(line, fd);
				rc   = $sscanf(line, "%s", tag);
				if (tag == "P") begin
					rc = $sscanf(line, "%s %h %h %h %h", tag, f_fid, f_dom, f_tclass, f_mask);
					write_policy();
				end else if (tag == "C") begin
					rc = $sscanf(line, "%s %h %h %h %h", tag, f_time, f_sub, f_sup, f_c2p);
					set_config();
				end else if (tag == "K") begin
					rc = $sscanf(line,
						"%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						tag, test_name, f_type3, f_fid, f_tid, f_rci, f_type1, f_disc, f_dom,
						f_src, f_buf, f_topic, f_flows, f_flags, e_vec, e_disc, e_pri,
						e_mcast, e_cls, e_tset, e_taddr, e_tdata);
					if (rc != 22) begin
						$display("Malformed packet line in the test data file");
						errors++;
					end else begin
						run_packet();
					end
				end
			end
			$fclose(fd);
		end

		$display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* logic/asa_top.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Action-set stage top level. Joins the slice decoder and the processor.
////////////////////////////////////////////////////////////////////////////

module asa_top import asa_pkg::*; #(
	parameter int FID_NBITS = 6,
	parameter int TID_NBITS = 5
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           in_valid,
	input  logic                           in_type3,
	input  logic [FID_NBITS-1:0]           in_fid,
	input  logic [TID_NBITS-1:0]           in_tid,
	input  logic [SCI_NBITS-1:0]           in_rci,
	input  logic                           in_type1,
	input  logic                           in_discard,
	input  logic [DOMAIN_NBITS-1:0]        in_domain_id,
	input  logic [SRC_PORT_NBITS-1:0]      in_src_port,
	input  logic [BUF_PTR_NBITS-1:0]       in_buf_ptr,
	input  ras_t                           in_ras,
	input  logic [REAL_TIME_NBITS-1:0]     current_time,
	input  logic [SUB_EXP_TIME_NBITS-1:0]  default_sub_exp_time,
	input  logic [SCI_NBITS-1:0]           supervisor_sci,
	input  logic [CLASS2PRI_NBITS-1:0]     class2pri,
	input  logic                           fp_wr,
	input  logic [FID_NBITS-1:0]           fp_waddr,
	input  flow_policy_t                   fp_wdata,
	output logic                           classifier_valid,
	output logic [FID_NBITS-1:0]           classifier_fid,
	output logic                           tset_wr,
	output logic [TID_NBITS+SCI_NBITS-1:0] tset_waddr,
	output logic [SUB_EXP_TIME_NBITS-1:0]  tset_wdata,
	output logic                           enq_req,
	output logic                           enq_discard,
	output logic                           enq_allow_mcast,
	output logic [SCI_VEC_NBITS-1:0]       enq_vec,
	output logic [PRI_NBITS-1:0]           enq_pri,
	output logic [SRC_PORT_NBITS-1:0]      enq_src_port,
	output logic [BUF_PTR_NBITS-1:0]       enq_buf_ptr,
	output logic [TID_NBITS-1:0]           enq_tid
);

	asa_ras_if ras_if ();

	ras_decode u_ras_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.ras      (in_ras),
		.ras_o    (ras_if.src)
	);

	asa_process #(
		.FID_NBITS (FID_NBITS),
		.TID_NBITS (TID_NBITS)
	) u_asa_process (
		.clk                  (clk),
		.arst_n               (arst_n),
		.in_valid             (in_valid),
		.in_type3             (in_type3),
		.in_fid               (in_fid),
		.in_tid               (in_tid),
		.in_rci               (in_rci),
		.in_type1             (in_type1),
		.in_discard           (in_discard),
		.in_domain_id         (in_domain_id),
		.in_src_port          (in_src_port),
		.in_buf_ptr           (in_buf_ptr),
		.current_time         (current_time),
		.default_sub_exp_time (default_sub_exp_time),
		.supervisor_sci       (supervisor_sci),
		.class2pri            (class2pri),
		.fp_wr                (fp_wr),
		.fp_waddr             (fp_waddr),
		.fp_wdata             (fp_wdata),
		.ras_i                (ras_if.dst),
		.classifier_valid     (classifier_valid),
		.classifier_fid       (classifier_fid),
		.tset_wr              (tset_wr),
		.tset_waddr           (tset_waddr),
		.tset_wdata           (tset_wdata),
		.enq_req              (enq_req),
		.enq_discard          (enq_discard),
		.enq_allow_mcast      (enq_allow_mcast),
		.enq_vec              (enq_vec),
		.enq_pri              (enq_pri),
		.enq_src_port         (enq_src_port),
		.enq_buf_ptr          (enq_buf_ptr),
		.enq_tid              (enq_tid)
	);

endmodule

/* logic/asa_process.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Action-set processor. Looks up the flow policy and the flow and topic
// action sets, applies the table updates and registers the enqueue
// request, the classifier terminate notice and the topic timer write.
////////////////////////////////////////////////////////////////////////////

module asa_process import asa_pkg::*; #(
	parameter int FID_NBITS = 6,
	parameter int TID_NBITS = 5
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           in_valid,
	input  logic                           in_type3,
	input  logic [FID_NBITS-1:0]           in_fid,
	input  logic [TID_NBITS-1:0]           in_tid,
	input  logic [SCI_NBITS-1:0]           in_rci,
	input  logic                           in_type1,
	input  logic                           in_discard,
	input  logic [DOMAIN_NBITS-1:0]        in_domain_id,
	input  logic [SRC_PORT_NBITS-1:0]      in_src_port,
	input  logic [BUF_PTR_NBITS-1:0]       in_buf_ptr,
	input  logic [REAL_TIME_NBITS-1:0]     current_time,
	input  logic [SUB_EXP_TIME_NBITS-1:0]  default_sub_exp_time,
	input  logic [SCI_NBITS-1:0]           supervisor_sci,
	input  logic [CLASS2PRI_NBITS-1:0]     class2pri,
	input  logic                           fp_wr,
	input  logic [FID_NBITS-1:0]           fp_waddr,
	input  flow_policy_t                   fp_wdata,
	asa_ras_if.dst                         ras_i,
	output logic                           classifier_valid,
	output logic [FID_NBITS-1:0]           classifier_fid,
	output logic                           tset_wr,
	output logic [TID_NBITS+SCI_NBITS-1:0] tset_waddr,
	output logic [SUB_EXP_TIME_NBITS-1:0]  tset_wdata,
	output logic                           enq_req,
	output logic                           enq_discard,
	output logic                           enq_allow_mcast,
	output logic [SCI_VEC_NBITS-1:0]       enq_vec,
	output logic [PRI_NBITS-1:0]           enq_pri,
	output logic [SRC_PORT_NBITS-1:0]      enq_src_port,
	output logic [BUF_PTR_NBITS-1:0]       enq_buf_ptr,
	output logic [TID_NBITS-1:0]           enq_tid
);

	asa_meta_t                meta_in;
	asa_meta_t                meta_d1;
	asa_meta_t                meta_d2;
	logic                     valid_d1;
	logic                     valid_d2;
	logic                     type3_d1;
	logic                     type3_d2;
	logic [FID_NBITS-1:0]     fid_d1;
	logic [FID_NBITS-1:0]     fid_d2;
	logic [TID_NBITS-1:0]     tid_d1;
	logic [TID_NBITS-1:0]     tid_d2;
	logic                     fp_wr_d1;
	logic [FID_NBITS-1:0]     fp_waddr_d1;
	flow_policy_t             fp_wdata_d1;
	flow_policy_t             pol_rd;
	flow_policy_t             pol_d2;
	flow_action_t             fa_rd;
	flow_action_t             fa_d2;
	flow_action_t             fa_wdata;
	logic [SCI_VEC_NBITS-1:0] ta_rd;
	logic [SCI_VEC_NBITS-1:0] ta_d2;
	logic [SCI_VEC_NBITS-1:0] ta_wdata;
	flow_mask_t               mask;
	ras_flags_t               flags;
	logic                     dom_miss;
	logic                     clean;
	logic                     fa_vec_wr;
	logic                     fa_def_wr;
	logic                     fa_wr;
	logic                     ta_wr;
	logic                     use_eflow;
	logic                     discard_p1;
	logic [SCI_VEC_NBITS-1:0] fwd_vec;
	logic [SCI_VEC_NBITS-1:0] rci_vec;
	logic [SCI_VEC_NBITS-1:0] sup_mask;
	logic [SCI_VEC_NBITS-1:0] vec_p1;
	logic [REAL_TIME_NBITS-1:0] exp_time;

	assign meta_in = '{
		rci:       in_rci,
		type1:     in_type1,
		discard:   in_discard,
		domain_id: in_domain_id,
		src_port:  in_src_port,
		buf_ptr:   in_buf_ptr
	};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
			fp_wr_d1 <= 1'b0;
		end else begin
			valid_d1 <= in_valid;
			valid_d2 <= valid_d1;
			fp_wr_d1 <= fp_wr;
		end
	end

	// Table read data is re-registered to line up with the decoded slice.
	always_ff @(posedge clk) begin
		type3_d1    <= in_type3;
		type3_d2    <= type3_d1;
		fid_d1      <= in_fid;
		fid_d2      <= fid_d1;
		tid_d1      <= in_tid;
		tid_d2      <= tid_d1;
		meta_d1     <= meta_in;
		meta_d2     <= meta_d1;
		fp_waddr_d1 <= fp_waddr;
		fp_wdata_d1 <= fp_wdata;
		pol_d2      <= pol_rd;
		fa_d2       <= fa_rd;
		ta_d2       <= ta_rd;
	end

	ram_1r1w #(.DATA_NBITS($bits(flow_policy_t)), .ADDR_NBITS(FID_NBITS)) u_fp_ram (
		.clk   (clk),
		.wr    (fp_wr_d1),
		.waddr (fp_waddr_d1),
		.din   (fp_wdata_d1),
		.raddr (in_fid),
		.dout  (pol_rd)
	);

	ram_1r1w #(.DATA_NBITS($bits(flow_action_t)), .ADDR_NBITS(FID_NBITS)) u_fa_ram (
		.clk   (clk),
		.wr    (fa_wr),
		.waddr (fid_d2),
		.din   (fa_wdata),
		.raddr (in_fid),
		.dout  (fa_rd)
	);

	ram_1r1w #(.DATA_NBITS(SCI_VEC_NBITS), .ADDR_NBITS(TID_NBITS)) u_ta_ram (
		.clk   (clk),
		.wr    (ta_wr),
		.waddr (tid_d2),
		.din   (ta_wdata),
		.raddr (in_tid),
		.dout  (ta_rd)
	);

	assign mask     = pol_d2.maskon;
	assign flags    = ras_i.flags;
	assign dom_miss = meta_d2.type1 & (meta_d2.domain_id != pol_d2.domain_id);
	assign clean    = valid_d2 & ~type3_d2 & ~meta_d2.discard & ~dom_miss & flags.east[2];

	assign fa_vec_wr = clean & flags.east[1] & (flags.nfascf == 2'b11) & ras_i.flow_any &
		mask.upd_flow;
	assign fa_def_wr = clean & flags.ufdast[2] & mask.upd_flow;
	assign fa_wr     = fa_vec_wr | fa_def_wr;
	assign fa_wdata  = '{
		def_type: fa_def_wr ? flags.ufdast[1:0] : fa_d2.def_type,
		act_set:  fa_vec_wr ? ras_i.flow_vec : fa_d2.act_set
	};

	assign ta_wr    = clean & flags.east[0] & ras_i.topic_valid & mask.upd_topic;
	assign ta_wdata = ta_d2 | ras_i.topic_vec; // Topic sets only grow.

	assign discard_p1 = meta_d2.discard | dom_miss |
		(type3_d2 ? (fa_d2.def_type == '0) : (flags.east[1:0] == 2'b00));

	assign use_eflow = flags.nfascf[1] & flags.east[1] & mask.exec_fwd;

	always_comb begin
		fwd_vec = '0;
		if (type3_d2) begin
			if (fa_d2.def_type[0] && mask.topic_fwd)
				fwd_vec |= ta_d2;
			if (fa_d2.def_type[1] && mask.flow_fwd)
				fwd_vec |= fa_d2.act_set;
		end else begin
			if (flags.east[0] && mask.topic_fwd)
				fwd_vec |= ta_d2;
			if (!use_eflow && mask.flow_fwd)
				fwd_vec |= fa_d2.act_set;
			if (flags.east[0] && mask.exec_fwd)
				fwd_vec |= ras_i.topic_vec;
			if (use_eflow)
				fwd_vec |= ras_i.flow_vec;
		end
	end

	assign rci_vec  = port_vec(ras_slot_t'{invalid: 1'b0, sci: meta_d2.rci});
	assign sup_mask = mask.sup_fwd ? '1 : ~port_vec(ras_slot_t'{invalid: 1'b0, sci: supervisor_sci});
	assign vec_p1   = discard_p1 ? '0 : (fwd_vec & ~rci_vec & sup_mask);

	assign exp_time = current_time +
		{default_sub_exp_time, {(REAL_TIME_NBITS-SUB_EXP_TIME_NBITS){1'b0}}};

	// Terminate notice goes out from stage 2.
	assign classifier_valid = valid_d2 & ~flags.east[2];
	assign classifier_fid   = FID_NBITS'(tid_d2);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enq_req <= 1'b0;
			tset_wr <= 1'b0;
		end else begin
			enq_req <= valid_d2;
			tset_wr <= ta_wr;
		end
	end

	always_ff @(posedge clk) begin
		tset_waddr      <= {tid_d2, ras_i.topic_sci};
		tset_wdata      <= exp_time[REAL_TIME_NBITS-1 -: SUB_EXP_TIME_NBITS];
		enq_discard     <= discard_p1;
		enq_allow_mcast <= mask.mcast;
		enq_vec         <= vec_p1;
		enq_pri         <= class2pri[pol_d2.tclass*PRI_NBITS +: PRI_NBITS];
		enq_src_port    <= meta_d2.src_port;
		enq_buf_ptr     <= meta_d2.buf_ptr;
		enq_tid         <= tid_d2;
	end

	discard_no_vec: assert property (@(posedge clk) disable iff (!arst_n)
		(enq_req && enq_discard) |-> (enq_vec == '0));

	// Type3 packets only read the tables, so they never arm a topic timer.
	type3_no_tset: assert property (@(posedge clk) disable iff (!arst_n)
		tset_wr |-> !$past(in_type3, 3));

endmodule

/* logic/ras_decode.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Routing action slice decoder. Registers the slice, turns the nine slots
// into one-hot port vectors and registers them with the flags.
////////////////////////////////////////////////////////////////////////////

module ras_decode import asa_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_valid,
	input  ras_t   ras,
	asa_ras_if.src ras_o
);

	ras_t                     ras_d1;
	logic                     valid_d1;
	logic [SCI_VEC_NBITS-1:0] flow_vec_p1;
	logic                     flow_any_p1;
	logic [SCI_VEC_NBITS-1:0] topic_vec_p1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_d1 <= 1'b0;
		else
			valid_d1 <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			ras_d1 <= ras;
	end

	always_comb begin
		flow_vec_p1 = '0;
		flow_any_p1 = 1'b0;
		for (int i = 0; i < RAS_FLOW_SLOTS; i++) begin
			flow_vec_p1 |= port_vec(ras_d1.flow[i]);
			flow_any_p1 |= ~ras_d1.flow[i].invalid;
		end
	end

	assign topic_vec_p1 = port_vec(ras_d1.topic);

	// Slot valids drop when no packet is in stage 1.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ras_o.flow_any    <= 1'b0;
			ras_o.topic_valid <= 1'b0;
		end else begin
			ras_o.flow_any    <= valid_d1 & flow_any_p1;
			ras_o.topic_valid <= valid_d1 & ~ras_d1.topic.invalid;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_d1) begin
			ras_o.flow_vec  <= flow_vec_p1;
			ras_o.topic_vec <= topic_vec_p1;
			ras_o.topic_sci <= ras_d1.topic.sci;
			ras_o.flags     <= ras_d1.flags;
		end
	end

endmodule

/* logic/ram_1r1w.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Register-array RAM with one write port and one registered read port.
////////////////////////////////////////////////////////////////////////////

module ram_1r1w #(
	parameter int DATA_NBITS = 8,
	parameter int ADDR_NBITS = 4
) (
	input  logic                  clk,
	input  logic                  wr,
	input  logic [ADDR_NBITS-1:0] waddr,
	input  logic [DATA_NBITS-1:0] din,
	input  logic [ADDR_NBITS-1:0] raddr,
	output logic [DATA_NBITS-1:0] dout
);

	localparam int DEPTH = 1 << ADDR_NBITS;

	// Tables come up empty.
	logic [DATA_NBITS-1:0] mem [DEPTH] = '{default: '0};

	// Read returns the old word on a same-address write.
	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
		dout <= mem[raddr];
	end

	write_addr_known: assert property (@(posedge clk) wr |-> !$isunknown(waddr));

endmodule

/* logic/asa_ras_if.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Decoded routing action slice, passed from the decoder to the processor.
////////////////////////////////////////////////////////////////////////////

interface asa_ras_if import asa_pkg::*; ();

	logic [SCI_VEC_NBITS-1:0] flow_vec;    // OR of all valid flow slots.
	logic                     flow_any;
	logic [SCI_VEC_NBITS-1:0] topic_vec;
	logic                     topic_valid;
	logic [SCI_NBITS-1:0]     topic_sci;
	ras_flags_t               flags;

	modport src (
		output flow_vec, flow_any, topic_vec, topic_valid, topic_sci, flags
	);

	modport dst (
		input flow_vec, flow_any, topic_vec, topic_valid, topic_sci, flags
	);

endinterface

/* logic/asa_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Action-set stage definitions: field widths, routing action slice and
// table entry layouts, and the slot to port vector decode.
////////////////////////////////////////////////////////////////////////////

package asa_pkg;

	localparam int SCI_NBITS          = 3;
	localparam int SCI_VEC_NBITS      = 1 << SCI_NBITS;
	localparam int PRI_NBITS          = 2;
	localparam int TCLASS_NBITS       = 3;
	localparam int CLASS2PRI_NBITS    = (1 << TCLASS_NBITS) * PRI_NBITS;
	localparam int DOMAIN_NBITS       = 4;
	localparam int SRC_PORT_NBITS     = 4;
	localparam int BUF_PTR_NBITS      = 10;
	localparam int ACT_TYPE_NBITS     = 2;
	localparam int REAL_TIME_NBITS    = 16;
	localparam int SUB_EXP_TIME_NBITS = 8;
	localparam int RAS_FLOW_SLOTS     = 8;

	typedef struct packed {
		logic                 invalid;
		logic [SCI_NBITS-1:0] sci;
	} ras_slot_t;

	typedef struct packed {
		logic [2:0] east;   // Continue flow, execute flow, execute topic.
		logic [1:0] nfascf; // Bit 1 allows forwarding, 3 allows update.
		logic [2:0] ufdast; // Write request and new default type.
	} ras_flags_t;

	// Flow slot 0 sits just above the flags.
	typedef struct packed {
		ras_slot_t                      topic;
		ras_slot_t [RAS_FLOW_SLOTS-1:0] flow;
		ras_flags_t                     flags;
	} ras_t;

	typedef struct packed {
		logic upd_flow;
		logic upd_topic;
		logic exec_fwd;
		logic flow_fwd;
		logic topic_fwd;
		logic mcast;
		logic sup_fwd;
	} flow_mask_t;

	typedef struct packed {
		logic [DOMAIN_NBITS-1:0] domain_id;
		logic [TCLASS_NBITS-1:0] tclass;
		flow_mask_t              maskon;
	} flow_policy_t;

	typedef struct packed {
		logic [ACT_TYPE_NBITS-1:0] def_type;
		logic [SCI_VEC_NBITS-1:0]  act_set;
	} flow_action_t;

	// Packet metadata without fid and tid, whose widths are module parameters.
	typedef struct packed {
		logic [SCI_NBITS-1:0]      rci;
		logic                      type1;
		logic                      discard;
		logic [DOMAIN_NBITS-1:0]   domain_id;
		logic [SRC_PORT_NBITS-1:0] src_port;
		logic [BUF_PTR_NBITS-1:0]  buf_ptr;
	} asa_meta_t;

	function automatic logic [SCI_VEC_NBITS-1:0] port_vec(input ras_slot_t slot);
		logic [SCI_VEC_NBITS-1:0] vec;
		vec = '0;
		if (!slot.invalid)
			vec[slot.sci] = 1'b1;
		return vec;
	endfunction

endpackage
